//--- perf_monitor.f
hw/perf_pkg.sv
hw/perf_event_decode.sv
hw/perf_core_counters.sv
hw/perf_state_histogram.sv
hw/perf_monitor.sv
test/perf_monitor_chk.sv
test/perf_monitor_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= perf_monitor_tb
FILELIST  ?= perf_monitor.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only if the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- test/perf_monitor_tb.sv
// Testbench that runs table and random rows through the performance monitor against a counting model
`timescale 1ns/1ps

module perf_monitor_tb import perf_pkg::*; ();

  localparam int unsigned NRET           = 2;
  localparam int unsigned NUM_TABLE      = 14;
  localparam int unsigned NUM_RANDOM     = 200;
  localparam int unsigned TIMEOUT_CYCLES = 16 + NUM_TABLE + NUM_RANDOM + 50;

  // Row layout commit[18:17], levels[16:7], ic[6:5], lsu[4:3], dc[2:0]
  // Levels grouped as fe v/r, dec v/r, rob_ready, flush, ic miss v/r, dc miss v/r
  localparam logic [18:0] STIM_TABLE [NUM_TABLE] = '{
    {2'b01, 10'b11_11_1_0_00_00, 2'd1, 2'd1, 3'd1},
    {2'b11, 10'b11_11_1_0_00_00, 2'd2, 2'd2, 3'd2},
    {2'b10, 10'b10_11_1_0_00_00, 2'd3, 2'd3, 3'd3},
    {2'b00, 10'b00_10_1_0_00_00, 2'd0, 2'd0, 3'd4},
    {2'b00, 10'b11_11_0_0_00_00, 2'd1, 2'd2, 3'd5},
    {2'b00, 10'b11_10_0_0_00_00, 2'd2, 2'd3, 3'd6},
    {2'b00, 10'b11_11_1_1_00_00, 2'd3, 2'd0, 3'd0},
    {2'b01, 10'b10_10_0_1_00_00, 2'd0, 2'd1, 3'd1},
    {2'b00, 10'b11_11_1_0_11_00, 2'd1, 2'd1, 3'd3},
    {2'b00, 10'b11_11_1_0_10_00, 2'd2, 2'd2, 3'd4},
    {2'b00, 10'b11_11_1_0_00_11, 2'd3, 2'd3, 3'd5},
    {2'b00, 10'b11_11_1_0_00_10, 2'd0, 2'd0, 3'd6},
    {2'b11, 10'b01_01_1_1_10_10, 2'd1, 2'd2, 3'd2},
    {2'b00, 10'b00_00_0_0_01_01, 2'd0, 2'd0, 3'd0}
  };

  logic           clk_i;
  logic           rst_ni;
  logic [NRET-1:0] commit_valid_i;
  pipe_levels_t   levels_i;
  icache_state_e  ic_state_i;
  lsu_state_e     lsu_state_i;
  dcache_state_e  dc_state_i;
  core_counters_t core_cnt_o;
  cnt_t [3:0]     ic_hist_o;
  cnt_t [3:0]     lsu_hist_o;
  cnt_t [6:0]     dc_hist_o;

  // Expected absolute values from the baseline snapshot on
  core_counters_t exp_cnt;
  cnt_t [3:0]     exp_ic;
  cnt_t [3:0]     exp_lsu;
  cnt_t [6:0]     exp_dc;
  int unsigned    cycle_cnt;

  perf_monitor #(.NRET(NRET)) i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .commit_valid_i (commit_valid_i),
    .levels_i       (levels_i),
    .ic_state_i     (ic_state_i),
    .lsu_state_i    (lsu_state_i),
    .dc_state_i     (dc_state_i),
    .core_cnt_o     (core_cnt_o),
    .ic_hist_o      (ic_hist_o),
    .lsu_hist_o     (lsu_hist_o),
    .dc_hist_o      (dc_hist_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string name, input cnt_t exp, input cnt_t act);
    assert (act == exp) else begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
      $display("Finished with errors");
      $fatal(1, "counter mismatch");
    end
  endtask

  task automatic check_all();
    check_value("cycles", exp_cnt.cycles, core_cnt_o.cycles);
    check_value("commit_cycles", exp_cnt.commit_cycles, core_cnt_o.commit_cycles);
    check_value("nocommit_cycles", exp_cnt.nocommit_cycles, core_cnt_o.nocommit_cycles);
    check_value("commit_instrs", exp_cnt.commit_instrs, core_cnt_o.commit_instrs);
    check_value("fe_empty_cycles", exp_cnt.fe_empty_cycles, core_cnt_o.fe_empty_cycles);
    check_value("fe_stall_cycles", exp_cnt.fe_stall_cycles, core_cnt_o.fe_stall_cycles);
    check_value("dec_stall_cycles", exp_cnt.dec_stall_cycles, core_cnt_o.dec_stall_cycles);
    check_value("rob_full_cycles", exp_cnt.rob_full_cycles, core_cnt_o.rob_full_cycles);
    check_value("flush_cycles", exp_cnt.flush_cycles, core_cnt_o.flush_cycles);
    check_value("ic_miss_cycles", exp_cnt.ic_miss_cycles, core_cnt_o.ic_miss_cycles);
    check_value("ic_miss_reqs", exp_cnt.ic_miss_reqs, core_cnt_o.ic_miss_reqs);
    check_value("dc_miss_cycles", exp_cnt.dc_miss_cycles, core_cnt_o.dc_miss_cycles);
    check_value("dc_miss_reqs", exp_cnt.dc_miss_reqs, core_cnt_o.dc_miss_reqs);
    for (int i = 0; i < 4; i++) begin
      check_value($sformatf("ic_hist_o[%0d]", i), exp_ic[i], ic_hist_o[i]);
      check_value($sformatf("lsu_hist_o[%0d]", i), exp_lsu[i], lsu_hist_o[i]);
    end
    for (int i = 0; i < 7; i++) begin
      check_value($sformatf("dc_hist_o[%0d]", i), exp_dc[i], dc_hist_o[i]);
    end
  endtask

  // Counting model built from the classification rules
  task automatic model_row(input logic [NRET-1:0] cv, input pipe_levels_t lv,
                           input icache_state_e ic, input lsu_state_e lsu,
                           input dcache_state_e dc);
    exp_cnt.cycles = exp_cnt.cycles + 1'b1;
    if (cv != '0) exp_cnt.commit_cycles = exp_cnt.commit_cycles + 1'b1;
    else exp_cnt.nocommit_cycles = exp_cnt.nocommit_cycles + 1'b1;
    for (int i = 0; i < NRET; i++) begin
      exp_cnt.commit_instrs = exp_cnt.commit_instrs + cnt_t'(cv[i]);
    end
    if (!lv.fe_valid) exp_cnt.fe_empty_cycles = exp_cnt.fe_empty_cycles + 1'b1;
    if (lv.fe_valid && !lv.fe_ready) exp_cnt.fe_stall_cycles = exp_cnt.fe_stall_cycles + 1'b1;
    if (lv.dec_valid && !lv.dec_ready) exp_cnt.dec_stall_cycles = exp_cnt.dec_stall_cycles + 1'b1;
    if (lv.dec_valid && !lv.rob_ready) exp_cnt.rob_full_cycles = exp_cnt.rob_full_cycles + 1'b1;
    if (lv.flush) exp_cnt.flush_cycles = exp_cnt.flush_cycles + 1'b1;
    if (lv.ic_miss_valid && !lv.ic_miss_ready)
      exp_cnt.ic_miss_cycles = exp_cnt.ic_miss_cycles + 1'b1;
    if (lv.ic_miss_valid) exp_cnt.ic_miss_reqs = exp_cnt.ic_miss_reqs + 1'b1;
    if (lv.dc_miss_valid && !lv.dc_miss_ready)
      exp_cnt.dc_miss_cycles = exp_cnt.dc_miss_cycles + 1'b1;
    if (lv.dc_miss_valid) exp_cnt.dc_miss_reqs = exp_cnt.dc_miss_reqs + 1'b1;
    exp_ic[ic]   = exp_ic[ic] + 1'b1;
    exp_lsu[lsu] = exp_lsu[lsu] + 1'b1;
    exp_dc[dc]   = exp_dc[dc] + 1'b1;
  endtask

  task automatic drive_row(input logic [NRET-1:0] cv, input pipe_levels_t lv,
                           input icache_state_e ic, input lsu_state_e lsu,
                           input dcache_state_e dc);
    commit_valid_i = cv;
    levels_i       = lv;
    ic_state_i     = ic;
    lsu_state_i    = lsu;
    dc_state_i     = dc;
  endtask

  task automatic next_slot();
    @(posedge clk_i);
    #2;
  endtask

  initial begin
    logic [18:0]   row;
    logic [1:0]    rnd_cv;
    pipe_levels_t  rnd_lv;
    icache_state_e rnd_ic;
    lsu_state_e    rnd_lsu;
    dcache_state_e rnd_dc;

    void'($urandom(32'haae1));
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    cycle_cnt = 0;
    drive_row('0, '0, IC_IDLE, LSU_IDLE, DC_IDLE);
    exp_cnt = '0;
    exp_ic  = '0;
    exp_lsu = '0;
    exp_dc  = '0;

    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // No edge with reset released yet
    check_all();

    repeat (3) next_slot();
    next_slot();
    exp_cnt = core_cnt_o;
    exp_ic  = ic_hist_o;
    exp_lsu = lsu_hist_o;
    exp_dc  = dc_hist_o;
    // Idle row still in flight at the baseline
    model_row('0, '0, IC_IDLE, LSU_IDLE, DC_IDLE);

    for (int i = 0; i < NUM_TABLE; i++) begin
      if (i != 0) next_slot();
      row = STIM_TABLE[i];
      drive_row(row[18:17], pipe_levels_t'(row[16:7]), icache_state_e'(row[6:5]),
                lsu_state_e'(row[4:3]), dcache_state_e'(row[2:0]));
      model_row(row[18:17], pipe_levels_t'(row[16:7]), icache_state_e'(row[6:5]),
                lsu_state_e'(row[4:3]), dcache_state_e'(row[2:0]));
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      next_slot();
      rnd_cv  = 2'($urandom);
      rnd_lv  = pipe_levels_t'(10'($urandom));
      rnd_ic  = icache_state_e'(2'($urandom));
      rnd_lsu = lsu_state_e'(2'($urandom));
      rnd_dc  = dcache_state_e'(3'($urandom_range(6, 0)));
      drive_row(rnd_cv, rnd_lv, rnd_ic, rnd_lsu, rnd_dc);
      model_row(rnd_cv, rnd_lv, rnd_ic, rnd_lsu, rnd_dc);
    end

    next_slot();
    drive_row('0, '0, IC_IDLE, LSU_IDLE, DC_IDLE);
    next_slot();
    check_all();

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- test/perf_monitor_chk.sv
// Bound assertions on the performance monitor top, checking counter bookkeeping invariants
`timescale 1ns/1ps

module perf_monitor_chk import perf_pkg::*; #(
  parameter int unsigned NRET = 2
) (
  input logic           clk_i,
  input logic           rst_ni,
  input core_counters_t core_cnt_o,
  input cnt_t [3:0]     ic_hist_o,
  input cnt_t [3:0]     lsu_hist_o,
  input cnt_t [6:0]     dc_hist_o
);

  cnt_t ic_sum;
  cnt_t lsu_sum;
  cnt_t dc_sum;

  // Every cycle lands in exactly one bin of each histogram
  always_comb begin
    ic_sum  = '0;
    lsu_sum = '0;
    dc_sum  = '0;
    for (int i = 0; i < 4; i++) begin
      ic_sum  = ic_sum + ic_hist_o[i];
      lsu_sum = lsu_sum + lsu_hist_o[i];
    end
    for (int i = 0; i < 7; i++) begin
      dc_sum = dc_sum + dc_hist_o[i];
    end
  end

  a_commit_split: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_t'(core_cnt_o.commit_cycles + core_cnt_o.nocommit_cycles) == core_cnt_o.cycles)
    else $error("commit_cycles plus nocommit_cycles differs from cycles");

  a_hist_sums: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ic_sum == core_cnt_o.cycles && lsu_sum == core_cnt_o.cycles &&
    dc_sum == core_cnt_o.cycles)
    else $error("a state histogram does not sum to cycles");

  a_commit_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_t'(core_cnt_o.commit_instrs - $past(core_cnt_o.commit_instrs)) <= cnt_t'(NRET))
    else $error("commit_instrs advanced by more than the retire width in one cycle");

endmodule

bind perf_monitor perf_monitor_chk #(.NRET(NRET)) i_chk (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .core_cnt_o (core_cnt_o),
  .ic_hist_o  (ic_hist_o),
  .lsu_hist_o (lsu_hist_o),
  .dc_hist_o  (dc_hist_o)
);

//--- hw/perf_monitor.sv
// Top of the performance monitor: event decoder feeding the core counters and three FSM histograms
`timescale 1ns/1ps

module perf_monitor import perf_pkg::*; #(
  parameter int unsigned NRET = 2
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic [NRET-1:0] commit_valid_i,
  input  pipe_levels_t   levels_i,
  input  icache_state_e  ic_state_i,
  input  lsu_state_e     lsu_state_i,
  input  dcache_state_e  dc_state_i,
  output core_counters_t core_cnt_o,
  output cnt_t [3:0]     ic_hist_o,
  output cnt_t [3:0]     lsu_hist_o,
  output cnt_t [6:0]     dc_hist_o
);

  localparam int unsigned IC_STATES  = 4;
  localparam int unsigned LSU_STATES = 4;
  localparam int unsigned DC_STATES  = 7;

  perf_events_t              events;
  logic [$clog2(NRET+1)-1:0] commit_cnt;
  icache_state_e             ic_state;
  lsu_state_e                lsu_state;
  dcache_state_e             dc_state;

  perf_event_decode #(
    .NRET(NRET)
  ) i_decode (
    .clk_i,
    .rst_ni,
    .commit_valid_i,
    .levels_i,
    .ic_state_i,
    .lsu_state_i,
    .dc_state_i,
    .events_o     (events),
    .commit_cnt_o (commit_cnt),
    .ic_state_o   (ic_state),
    .lsu_state_o  (lsu_state),
    .dc_state_o   (dc_state)
  );

  perf_core_counters #(
    .NRET(NRET)
  ) i_core_counters (
    .clk_i,
    .rst_ni,
    .events_i     (events),
    .commit_cnt_i (commit_cnt),
    .cnt_o        (core_cnt_o)
  );

  // Histograms see the same registered cycle as the core counters
  perf_state_histogram #(.NUM_STATES(IC_STATES)) i_ic_hist (
    .clk_i,
    .rst_ni,
    .state_i (ic_state),
    .hist_o  (ic_hist_o)
  );

  perf_state_histogram #(.NUM_STATES(LSU_STATES)) i_lsu_hist (
    .clk_i,
    .rst_ni,
    .state_i (lsu_state),
    .hist_o  (lsu_hist_o)
  );

  perf_state_histogram #(.NUM_STATES(DC_STATES)) i_dc_hist (
    .clk_i,
    .rst_ni,
    .state_i (dc_state),
    .hist_o  (dc_hist_o)
  );

endmodule

//--- hw/perf_state_histogram.sv
// Occupancy histogram of one controller FSM, one counter per state code
`timescale 1ns/1ps

module perf_state_histogram import perf_pkg::*; #(
  parameter int unsigned NUM_STATES = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [$clog2(NUM_STATES)-1:0] state_i,
  output cnt_t [NUM_STATES-1:0]         hist_o
);

  localparam int unsigned SW = $clog2(NUM_STATES);

  cnt_t [NUM_STATES-1:0] hist_q;

  // Unused codes fall through and leave every bin alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '0;
    end else begin
      for (int i = 0; i < NUM_STATES; i++) begin
        if (state_i == SW'(i)) begin
          hist_q[i] <= hist_q[i] + 1'b1;
        end
      end
    end
  end

  assign hist_o = hist_q;

endmodule

//--- hw/perf_core_counters.sv
// Free-running pipeline event counters, advanced by the registered event word each cycle
`timescale 1ns/1ps

module perf_core_counters import perf_pkg::*; #(
  parameter int unsigned NRET = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  perf_events_t              events_i,
  input  logic [$clog2(NRET+1)-1:0] commit_cnt_i,
  output core_counters_t            cnt_o
);

  core_counters_t cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q.cycles <= cnt_q.cycles + 1'b1;

      // Every cycle lands in exactly one of the two
      if (events_i.commit_any) begin
        cnt_q.commit_cycles <= cnt_q.commit_cycles + 1'b1;
      end else begin
        cnt_q.nocommit_cycles <= cnt_q.nocommit_cycles + 1'b1;
      end
      cnt_q.commit_instrs <= cnt_q.commit_instrs + CNT_W'(commit_cnt_i);

      if (events_i.fe_empty) begin
        cnt_q.fe_empty_cycles <= cnt_q.fe_empty_cycles + 1'b1;
      end
      if (events_i.fe_stall) begin
        cnt_q.fe_stall_cycles <= cnt_q.fe_stall_cycles + 1'b1;
      end
      if (events_i.dec_stall) begin
        cnt_q.dec_stall_cycles <= cnt_q.dec_stall_cycles + 1'b1;
      end
      if (events_i.rob_full) begin
        cnt_q.rob_full_cycles <= cnt_q.rob_full_cycles + 1'b1;
      end
      if (events_i.flush) begin
        cnt_q.flush_cycles <= cnt_q.flush_cycles + 1'b1;
      end

      // Miss requests count on valid, stalls only while not accepted
      if (events_i.ic_miss_stall) begin
        cnt_q.ic_miss_cycles <= cnt_q.ic_miss_cycles + 1'b1;
      end
      if (events_i.ic_miss_req) begin
        cnt_q.ic_miss_reqs <= cnt_q.ic_miss_reqs + 1'b1;
      end
      if (events_i.dc_miss_stall) begin
        cnt_q.dc_miss_cycles <= cnt_q.dc_miss_cycles + 1'b1;
      end
      if (events_i.dc_miss_req) begin
        cnt_q.dc_miss_reqs <= cnt_q.dc_miss_reqs + 1'b1;
      end
    end
  end

  assign cnt_o = cnt_q;

endmodule

//--- hw/perf_event_decode.sv
// Classifies one cycle of pipeline levels and registers the event word, commit count and states
`timescale 1ns/1ps

module perf_event_decode import perf_pkg::*; #(
  parameter int unsigned NRET = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [NRET-1:0]             commit_valid_i,
  input  pipe_levels_t                levels_i,
  input  icache_state_e               ic_state_i,
  input  lsu_state_e                  lsu_state_i,
  input  dcache_state_e               dc_state_i,
  output perf_events_t                events_o,
  output logic [$clog2(NRET+1)-1:0]   commit_cnt_o,
  output icache_state_e               ic_state_o,
  output lsu_state_e                  lsu_state_o,
  output dcache_state_e               dc_state_o
);

  localparam int unsigned CC_W = $clog2(NRET + 1);

  perf_events_t    events_d;
  perf_events_t    events_q;
  logic [CC_W-1:0] commit_cnt_d;
  logic [CC_W-1:0] commit_cnt_q;
  icache_state_e   ic_state_q;
  lsu_state_e      lsu_state_q;
  dcache_state_e   dc_state_q;

  // Number of retire lanes committing this cycle
  always_comb begin
    commit_cnt_d = '0;
    for (int i = 0; i < NRET; i++) begin
      commit_cnt_d = commit_cnt_d + CC_W'(commit_valid_i[i]);
    end
  end

  always_comb begin
    events_d.commit_any    = |commit_valid_i;
    events_d.fe_empty      = !levels_i.fe_valid;
    events_d.fe_stall      = levels_i.fe_valid && !levels_i.fe_ready;
    events_d.dec_stall     = levels_i.dec_valid && !levels_i.dec_ready;
    // ROB back-pressure only matters while decode has something to hand over
    events_d.rob_full      = levels_i.dec_valid && !levels_i.rob_ready;
    events_d.flush         = levels_i.flush;
    events_d.ic_miss_stall = levels_i.ic_miss_valid && !levels_i.ic_miss_ready;
    events_d.ic_miss_req   = levels_i.ic_miss_valid;
    events_d.dc_miss_stall = levels_i.dc_miss_valid && !levels_i.dc_miss_ready;
    events_d.dc_miss_req   = levels_i.dc_miss_valid;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      events_q     <= '0;
      commit_cnt_q <= '0;
      ic_state_q   <= IC_IDLE;
      lsu_state_q  <= LSU_IDLE;
      dc_state_q   <= DC_IDLE;
    end else begin
      events_q     <= events_d;
      commit_cnt_q <= commit_cnt_d;
      ic_state_q   <= ic_state_i;
      lsu_state_q  <= lsu_state_i;
      dc_state_q   <= dc_state_i;
    end
  end

  assign events_o     = events_q;
  assign commit_cnt_o = commit_cnt_q;
  assign ic_state_o   = ic_state_q;
  assign lsu_state_o  = lsu_state_q;
  assign dc_state_o   = dc_state_q;

endmodule

//--- hw/perf_pkg.sv
// Shared types for the performance monitor: counter width, controller states, event words
package perf_pkg;

  localparam int unsigned CNT_W = 32;

  typedef logic [CNT_W-1:0] cnt_t;

  // Encodings follow the controllers' own state registers
  typedef enum logic [1:0] {
    IC_IDLE      = 2'd0,
    IC_LOOKUP    = 2'd1,
    IC_MISS_REQ  = 2'd2,
    IC_MISS_WAIT = 2'd3
  } icache_state_e;

  typedef enum logic [1:0] {
    LSU_IDLE   = 2'd0,
    LSU_LD_REQ = 2'd1,
    LSU_LD_RSP = 2'd2,
    LSU_RESP   = 2'd3
  } lsu_state_e;

  typedef enum logic [2:0] {
    DC_IDLE        = 3'd0,
    DC_LOOKUP      = 3'd1,
    DC_STORE_WRITE = 3'd2,
    DC_WB_REQ      = 3'd3,
    DC_MISS_REQ    = 3'd4,
    DC_WAIT_REFILL = 3'd5,
    DC_RESP        = 3'd6
  } dcache_state_e;

  // Raw per-cycle pipeline levels
  typedef struct packed {
    logic fe_valid;
    logic fe_ready;
    logic dec_valid;
    logic dec_ready;
    logic rob_ready;
    logic flush;
    logic ic_miss_valid;
    logic ic_miss_ready;
    logic dc_miss_valid;
    logic dc_miss_ready;
  } pipe_levels_t;

  // One cycle's classified flags, as registered by the decoder
  typedef struct packed {
    logic commit_any;
    logic fe_empty;
    logic fe_stall;
    logic dec_stall;
    logic rob_full;
    logic flush;
    logic ic_miss_stall;
    logic ic_miss_req;
    logic dc_miss_stall;
    logic dc_miss_req;
  } perf_events_t;

  typedef struct packed {
    cnt_t cycles;
    cnt_t commit_cycles;
    cnt_t nocommit_cycles;
    cnt_t commit_instrs;
    cnt_t fe_empty_cycles;
    cnt_t fe_stall_cycles;
    cnt_t dec_stall_cycles;
    cnt_t rob_full_cycles;
    cnt_t flush_cycles;
    cnt_t ic_miss_cycles;
    cnt_t ic_miss_reqs;
    cnt_t dc_miss_cycles;
    cnt_t dc_miss_reqs;
  } core_counters_t;

endpackage
